/* hdl/gopigo_spi_pkg.sv */
// shared widths, setting indices, step rules and spi constants for the gopigo link
// imported by every rtl module of the bring-up harness
package gopigo_spi_pkg;

  typedef logic [7:0]  byte_t;  // one spi byte
  typedef logic [7:0]  pwm_t;   // motor pwm, two's complement
  typedef logic [23:0] rgb_t;   // r[23:16] g[15:8] b[7:0]
  typedef logic [2:0]  sel_t;   // setting index

  // setting indices, also the frame order
  localparam sel_t SEL_MOTOR_LEFT = 3'd0;
  localparam sel_t SEL_MOTOR_RGHT = 3'd1;
  localparam sel_t SEL_EYE_LEFT   = 3'd2;
  localparam sel_t SEL_EYE_RGHT   = 3'd3;
  localparam sel_t SEL_BLINK_LEFT = 3'd4;
  localparam sel_t SEL_BLINK_RGHT = 3'd5;
  localparam int   NUM_SEL        = 6;

  // button stepping
  localparam pwm_t  PWM_STEP = 8'd32;
  localparam pwm_t  PWM_WRAP = 8'd192;  // at or above this the motor goes back to 0
  localparam byte_t LED_STEP = 8'd32;
  localparam byte_t LED_WRAP = 8'd128;  // a channel at or above this clears the colour

  // command byte per setting
  localparam byte_t CMD_MOTOR_LEFT = 8'h10;
  localparam byte_t CMD_MOTOR_RGHT = 8'h11;
  localparam byte_t CMD_EYE_LEFT   = 8'h20;
  localparam byte_t CMD_EYE_RGHT   = 8'h21;
  localparam byte_t CMD_BLINK_LEFT = 8'h30;
  localparam byte_t CMD_BLINK_RGHT = 8'h31;

  // spi timing in system clocks
  localparam int SCLK_HALF_DIV = 4;  // sclk half period
  localparam int FRAME_GAP     = 8;  // ss_n high time between frames
  localparam int DIV_CNT_W     = $clog2(SCLK_HALF_DIV);
  localparam int GAP_CNT_W     = $clog2(FRAME_GAP);

endpackage

/* hdl/spi_byte_master.sv */
// spi mode 0 byte shifter, msb first, sclk divided from the system clock
// one byte takes 16 * SCLK_HALF_DIV clocks from tx_start_i to tx_done_o
`timescale 1ns/1ps

module spi_byte_master
  import gopigo_spi_pkg::*;
(
  input  logic  rst,
  input  logic  clk,
  input  logic  tx_start_i,
  input  byte_t tx_byte_i,
  input  logic  miso_i,
  output logic  tx_done_o,
  output byte_t rx_byte_o,
  output logic  sclk_o,
  output logic  mosi_o
);

  typedef enum logic {IDLE, SHIFT} shift_state_t;

  shift_state_t           state_q;
  logic [DIV_CNT_W-1:0]   div_q;   // clocks into the current sclk half
  logic [2:0]             bit_q;
  byte_t                  tx_sh_q;
  byte_t                  rx_sh_q;

  logic half_end;
  logic rise;
  logic fall;
  logic last_fall;

  assign half_end  = (state_q == SHIFT) && (div_q == DIV_CNT_W'(SCLK_HALF_DIV - 1));
  assign rise      = half_end & ~sclk_o;
  assign fall      = half_end & sclk_o;
  assign last_fall = fall && (bit_q == 3'd7);

  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      state_q   <= IDLE;
      div_q     <= '0;
      bit_q     <= '0;
      sclk_o    <= 1'b0;
      mosi_o    <= 1'b0;
      tx_done_o <= 1'b0;
    end else begin
      tx_done_o <= 1'b0;
      case (state_q)
        IDLE: if (tx_start_i) begin
          state_q <= SHIFT;
          // start cycle counts as the first clock of the first half period
          div_q   <= DIV_CNT_W'(1);
          bit_q   <= '0;
          mosi_o  <= tx_byte_i[7];  // msb set up before the first rising edge
        end
        SHIFT: begin
          if (half_end) begin
            div_q  <= '0;
            sclk_o <= ~sclk_o;
            if (last_fall) begin
              state_q   <= IDLE;
              tx_done_o <= 1'b1;
            end else if (fall) begin
              bit_q  <= bit_q + 3'd1;
              mosi_o <= tx_sh_q[6];  // next bit on the falling edge
            end
          end else begin
            div_q <= div_q + 1'b1;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge rst) begin
    if (state_q == IDLE && tx_start_i)
      tx_sh_q <= tx_byte_i;
    else if (fall)
      tx_sh_q <= {tx_sh_q[6:0], 1'b0};
    if (rise)
      rx_sh_q <= {rx_sh_q[6:0], miso_i};  // miso sampled on rising sclk
    if (last_fall)
      rx_byte_o <= rx_sh_q;
  end

  a_sclk_idle_low: assert property (@(posedge rst) disable iff (clk)
    (state_q == IDLE) |-> !sclk_o);

endmodule

/* hdl/spi_frame_sequencer.sv */
// sends the six setting frames round robin: command byte then 1 or 3 payload bytes
// keeps the status byte returned during the command and the running flag
`timescale 1ns/1ps

module spi_frame_sequencer
  import gopigo_spi_pkg::*;
(
  input  logic  rst,
  input  logic  clk,
  input  pwm_t  motor_pwm_left_i,
  input  pwm_t  motor_pwm_rght_i,
  input  rgb_t  led_eye_left_rgb_i,
  input  rgb_t  led_eye_rght_rgb_i,
  input  rgb_t  led_blink_left_rgb_i,
  input  rgb_t  led_blink_rght_rgb_i,
  input  logic  tx_done_i,
  input  byte_t rx_byte_i,
  output logic  tx_start_o,
  output byte_t tx_byte_o,
  output logic  spi_ss_n_o,
  output logic  rpi_running_o,
  output byte_t status_o
);

  typedef enum logic [1:0] {GAP, CMD, PAYLOAD, END} seq_state_t;

  seq_state_t             state_q;
  sel_t                   idx_q;     // setting of the current frame
  logic [GAP_CNT_W-1:0]   gap_q;
  logic [1:0]             left_q;    // payload bytes still to send
  rgb_t                   pay_q;     // next payload byte sits in [23:16]

  byte_t      frame_cmd;
  rgb_t       frame_pay;
  logic [1:0] frame_len;
  logic       start_frame;
  logic       send_next;

  // motor values ride in the top byte so every frame shifts out the same way
  always_comb begin
    frame_cmd = CMD_MOTOR_LEFT;
    frame_pay = {motor_pwm_left_i, 16'h0};
    frame_len = 2'd1;
    case (idx_q)
      SEL_MOTOR_RGHT: begin
        frame_cmd = CMD_MOTOR_RGHT;
        frame_pay = {motor_pwm_rght_i, 16'h0};
      end
      SEL_EYE_LEFT: begin
        frame_cmd = CMD_EYE_LEFT;
        frame_pay = led_eye_left_rgb_i;
        frame_len = 2'd3;
      end
      SEL_EYE_RGHT: begin
        frame_cmd = CMD_EYE_RGHT;
        frame_pay = led_eye_rght_rgb_i;
        frame_len = 2'd3;
      end
      SEL_BLINK_LEFT: begin
        frame_cmd = CMD_BLINK_LEFT;
        frame_pay = led_blink_left_rgb_i;
        frame_len = 2'd3;
      end
      SEL_BLINK_RGHT: begin
        frame_cmd = CMD_BLINK_RGHT;
        frame_pay = led_blink_rght_rgb_i;
        frame_len = 2'd3;
      end
      default: ;  // SEL_MOTOR_LEFT
    endcase
  end

  assign start_frame = (state_q == GAP) && (gap_q == GAP_CNT_W'(FRAME_GAP - 1));
  assign send_next   = tx_done_i && ((state_q == CMD) || (state_q == PAYLOAD && left_q != 2'd1));

  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      state_q       <= GAP;
      idx_q         <= SEL_MOTOR_LEFT;
      gap_q         <= '0;
      left_q        <= '0;
      tx_start_o    <= 1'b0;
      spi_ss_n_o    <= 1'b1;
      rpi_running_o <= 1'b0;
      status_o      <= '0;
    end else begin
      tx_start_o <= 1'b0;
      case (state_q)
        GAP: begin
          gap_q <= gap_q + 1'b1;
          if (start_frame) begin
            spi_ss_n_o <= 1'b0;
            tx_start_o <= 1'b1;  // command byte
            left_q     <= frame_len;
            state_q    <= CMD;
          end
        end
        CMD: if (tx_done_i) begin
          status_o   <= rx_byte_i;
          tx_start_o <= 1'b1;
          state_q    <= PAYLOAD;
        end
        PAYLOAD: if (tx_done_i) begin
          if (left_q == 2'd1) begin
            state_q <= END;
          end else begin
            left_q     <= left_q - 2'd1;
            tx_start_o <= 1'b1;
          end
        end
        END: begin
          spi_ss_n_o <= 1'b1;
          gap_q      <= '0;
          if (idx_q == SEL_BLINK_RGHT)
            rpi_running_o <= 1'b1;  // first full round done
          idx_q   <= (idx_q == sel_t'(NUM_SEL - 1)) ? '0 : idx_q + 3'd1;
          state_q <= GAP;
        end
        default: state_q <= GAP;
      endcase
    end
  end

  // payload sampled once per frame, then shifted out a byte at a time
  always_ff @(posedge rst) begin
    if (start_frame) begin
      pay_q     <= frame_pay;
      tx_byte_o <= frame_cmd;
    end else if (send_next) begin
      tx_byte_o <= pay_q[23:16];
      pay_q     <= {pay_q[15:0], 8'h00};
    end
  end

  a_start_in_frame: assert property (@(posedge rst) disable iff (clk)
    tx_start_o |-> !spi_ss_n_o);

endmodule

/* hdl/top_spi_controller.sv */
// spi controller: frame sequencer feeding the byte shifter
`timescale 1ns/1ps

module top_spi_controller
  import gopigo_spi_pkg::*;
(
  input  logic  rst,
  input  logic  clk,
  input  pwm_t  motor_pwm_left_i,
  input  pwm_t  motor_pwm_rght_i,
  input  rgb_t  led_eye_left_rgb_i,
  input  rgb_t  led_eye_rght_rgb_i,
  input  rgb_t  led_blink_left_rgb_i,
  input  rgb_t  led_blink_rght_rgb_i,
  input  logic  miso_i,
  output logic  sclk_o,
  output logic  mosi_o,
  output logic  spi_ss_n_o,
  output logic  rpi_running_o,
  output byte_t status_o
);

  logic  tx_start;
  byte_t tx_byte;
  logic  tx_done;
  byte_t rx_byte;

  spi_frame_sequencer i_seq (
    .rst (rst), .clk (clk),
    .motor_pwm_left_i (motor_pwm_left_i), .motor_pwm_rght_i (motor_pwm_rght_i),
    .led_eye_left_rgb_i (led_eye_left_rgb_i), .led_eye_rght_rgb_i (led_eye_rght_rgb_i),
    .led_blink_left_rgb_i (led_blink_left_rgb_i),
    .led_blink_rght_rgb_i (led_blink_rght_rgb_i),
    .tx_done_i (tx_done), .rx_byte_i (rx_byte),
    .tx_start_o (tx_start), .tx_byte_o (tx_byte), .spi_ss_n_o (spi_ss_n_o),
    .rpi_running_o (rpi_running_o), .status_o (status_o)
  );

  spi_byte_master i_master (
    .rst (rst), .clk (clk),
    .tx_start_i (tx_start), .tx_byte_i (tx_byte), .miso_i (miso_i),
    .tx_done_o (tx_done), .rx_byte_o (rx_byte), .sclk_o (sclk_o), .mosi_o (mosi_o)
  );

endmodule

/* hdl/btntest_spi_controller.sv */
// bring-up top: each press of btn2 steps one robot setting, round robin
// the spi controller keeps sending all six settings to the board
`timescale 1ns/1ps

module btntest_spi_controller
  import gopigo_spi_pkg::*;
(
  input  logic  rst,            // system clock
  input  logic  clk,            // async reset, active high
  input  logic  btn2_i,
  input  logic  miso_i,
  output logic  sclk_o,
  output logic  mosi_o,
  output logic  spi_ss_n_o,     // slave select, active low
  output logic  rpi_running_o,  // tells the board the link is up
  output byte_t status_o
);

  logic btn_meta_q;
  logic btn_sync_q;
  logic btn_prev_q;
  logic press;

  sel_t cursor_q;  // setting changed by the next press

  pwm_t motor_pwm_left_q;
  pwm_t motor_pwm_rght_q;
  rgb_t led_eye_left_rgb_q;
  rgb_t led_eye_rght_rgb_q;
  rgb_t led_blink_left_rgb_q;
  rgb_t led_blink_rght_rgb_q;

  function automatic pwm_t step_pwm(input pwm_t v);
    return (v >= PWM_WRAP) ? '0 : v + PWM_STEP;
  endfunction

  // steps the channel at lsb, a full channel clears the whole colour
  function automatic rgb_t step_rgb(input rgb_t v, input int unsigned lsb);
    rgb_t nxt;
    nxt = v;
    if (v[lsb +: 8] >= LED_WRAP)
      nxt = '0;
    else
      nxt[lsb +: 8] = v[lsb +: 8] + LED_STEP;
    return nxt;
  endfunction

  // two flop synchronizer plus one more for the edge
  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      btn_meta_q <= 1'b0;
      btn_sync_q <= 1'b0;
      btn_prev_q <= 1'b0;
    end else begin
      btn_meta_q <= btn2_i;
      btn_sync_q <= btn_meta_q;
      btn_prev_q <= btn_sync_q;
    end
  end

  assign press = btn_sync_q & ~btn_prev_q;

  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      cursor_q <= '0;
    end else if (press) begin
      if (cursor_q == sel_t'(NUM_SEL - 1))
        cursor_q <= '0;
      else
        cursor_q <= cursor_q + 3'd1;
    end
  end

  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      motor_pwm_left_q     <= '0;
      motor_pwm_rght_q     <= '0;
      led_eye_left_rgb_q   <= '0;
      led_eye_rght_rgb_q   <= '0;
      led_blink_left_rgb_q <= '0;
      led_blink_rght_rgb_q <= '0;
    end else if (press) begin
      case (cursor_q)
        SEL_MOTOR_LEFT: motor_pwm_left_q     <= step_pwm(motor_pwm_left_q);
        SEL_MOTOR_RGHT: motor_pwm_rght_q     <= step_pwm(motor_pwm_rght_q);
        SEL_EYE_LEFT:   led_eye_left_rgb_q   <= step_rgb(led_eye_left_rgb_q, 0);    // blue
        SEL_EYE_RGHT:   led_eye_rght_rgb_q   <= step_rgb(led_eye_rght_rgb_q, 8);    // green
        SEL_BLINK_LEFT: led_blink_left_rgb_q <= step_rgb(led_blink_left_rgb_q, 16); // red
        SEL_BLINK_RGHT: begin
          // all three channels together, blue decides the wrap
          if (led_blink_rght_rgb_q[7:0] >= LED_WRAP)
            led_blink_rght_rgb_q <= '0;
          else
            led_blink_rght_rgb_q <= led_blink_rght_rgb_q + {3{LED_STEP}};
        end
        default: ;
      endcase
    end
  end

  top_spi_controller i_top_spi_ctrl (
    .rst                  (rst),
    .clk                  (clk),
    .motor_pwm_left_i     (motor_pwm_left_q),
    .motor_pwm_rght_i     (motor_pwm_rght_q),
    .led_eye_left_rgb_i   (led_eye_left_rgb_q),
    .led_eye_rght_rgb_i   (led_eye_rght_rgb_q),
    .led_blink_left_rgb_i (led_blink_left_rgb_q),
    .led_blink_rght_rgb_i (led_blink_rght_rgb_q),
    .miso_i               (miso_i),
    .sclk_o               (sclk_o),
    .mosi_o               (mosi_o),
    .spi_ss_n_o           (spi_ss_n_o),
    .rpi_running_o        (rpi_running_o),
    .status_o             (status_o)
  );

  a_cursor_range: assert property (@(posedge rst) disable iff (clk)
    cursor_q <= sel_t'(NUM_SEL - 1));

endmodule

/* sim/tb_clk_gen.sv */
// free running system clock for the testbench, 4 ns period
`timescale 1ns/1ps

module tb_clk_gen (
  output logic rst_o  // system clock
);

  initial rst_o = 1'b0;

  always #2 rst_o = ~rst_o;

endmodule

/* sim/tb_spi_slave_model.sv */
// robot board stand-in on the spi pins: collects each frame and answers with a status byte
// the status is a new xorshift value at every frame start
`timescale 1ns/1ps

module tb_spi_slave_model (
  input  logic        sclk_i,
  input  logic        mosi_i,
  input  logic        ss_n_i,
  output logic        miso_o,
  output int          frame_cnt_o,  // frames finished since reset
  output logic [7:0]  cmd_o,
  output logic [23:0] pay_o,        // payload bytes, first byte highest
  output int          len_o,        // payload bytes in the last frame
  output logic [7:0]  status_o      // status sent during that frame's command byte
);

  logic [7:0]  rng;
  logic [7:0]  status;
  logic [7:0]  rx_sh;
  logic [7:0]  cmd;
  logic [23:0] pay;
  int          bit_cnt;  // bits received in the current frame

  function automatic logic [7:0] xorshift8(input logic [7:0] x);
    logic [7:0] y;
    y = x ^ (x << 3);
    y = y ^ (y >> 5);
    y = y ^ (y << 4);
    return y;
  endfunction

  initial begin
    rng         = 8'd98;  // seed
    status      = 8'd0;
    miso_o      = 1'b0;
    frame_cnt_o = 0;
    bit_cnt     = 0;
    pay         = '0;
  end

  // receive side, mosi sampled on rising sclk, frame reported when ss_n rises
  always @(posedge sclk_i or posedge ss_n_i) begin
    if (ss_n_i == 1'b1) begin
      if (bit_cnt > 0) begin
        cmd_o       <= cmd;
        pay_o       <= pay;
        len_o       <= bit_cnt / 8 - 1;
        status_o    <= status;
        frame_cnt_o <= frame_cnt_o + 1;
        bit_cnt      = 0;
        pay          = '0;
      end
    end else begin
      rx_sh   = {rx_sh[6:0], mosi_i};
      bit_cnt = bit_cnt + 1;
      if (bit_cnt == 8)
        cmd = rx_sh;
      else if (bit_cnt % 8 == 0)
        pay = {pay[15:0], rx_sh};
    end
  end

  // transmit side, status msb first, changing on falling sclk
  always @(negedge ss_n_i or negedge sclk_i) begin
    if (ss_n_i == 1'b0) begin
      if (bit_cnt == 0) begin  // frame start
        rng    = xorshift8(rng);
        status = rng;
        miso_o <= rng[7];
      end else begin
        miso_o <= (bit_cnt < 8) ? status[3'(7 - bit_cnt)] : 1'b0;
      end
    end
  end

endmodule

/* sim/tb_btntest_spi.sv */
// testbench top for the spi bring-up harness
// walks sim/spi_golden.txt: presses the button, then checks the frames that follow
`timescale 1ns/1ps

module tb_btntest_spi;

  localparam int MAX_STEPS     = 64;
  localparam int FRAME_TIMEOUT = 6000;  // clocks, a bit over four frame rounds

  logic        rst;  // clock
  logic        clk;  // reset
  logic        btn2;
  logic        miso;
  logic        sclk;
  logic        mosi;
  logic        ss_n;
  logic        running;
  logic [7:0]  status;

  int          frame_cnt;
  logic [7:0]  frame_cmd;
  logic [23:0] frame_pay;
  int          frame_len;
  logic [7:0]  frame_status;

  logic [39:0] steps [MAX_STEPS];  // presses, command, payload
  logic [7:0]  cmd_order [6];
  int          err_cnt;
  int          timeout_cnt;

  tb_clk_gen i_clk_gen (.rst_o(rst));

  btntest_spi_controller dut0 (
    .rst           (rst),
    .clk           (clk),
    .btn2_i        (btn2),
    .miso_i        (miso),
    .sclk_o        (sclk),
    .mosi_o        (mosi),
    .spi_ss_n_o    (ss_n),
    .rpi_running_o (running),
    .status_o      (status)
  );

  tb_spi_slave_model i_slave (
    .sclk_i      (sclk),
    .mosi_i      (mosi),
    .ss_n_i      (ss_n),
    .miso_o      (miso),
    .frame_cnt_o (frame_cnt),
    .cmd_o       (frame_cmd),
    .pay_o       (frame_pay),
    .len_o       (frame_len),
    .status_o    (frame_status)
  );

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("CHECK FAILED %s expected %0h actual %0h", name, expected, actual);
      err_cnt++;
    end
  endtask

  task automatic press_button(input int count);
    repeat (count) begin
      @(posedge rst);
      btn2 <= 1'b1;
      repeat (4) @(posedge rst);
      btn2 <= 1'b0;
      repeat (4) @(posedge rst);
    end
  endtask

  // every frame seen on the way is checked for order and length
  task automatic wait_for_command(input logic [7:0] cmd, output bit found);
    int hits;
    int cycles;
    int last_cnt;
    int slot;
    hits     = 0;
    cycles   = 0;
    last_cnt = frame_cnt;
    while (hits < 2 && cycles < FRAME_TIMEOUT) begin
      @(negedge rst);
      cycles++;
      if (frame_cnt != last_cnt) begin
        last_cnt = frame_cnt;
        slot     = (frame_cnt - 1) % 6;  // nth frame since reset is setting (n-1) mod 6
        check_value($sformatf("frame %0d command", frame_cnt),
                    32'(cmd_order[slot]), 32'(frame_cmd));
        check_value($sformatf("frame %0d length", frame_cnt),
                    (slot < 2) ? 32'd1 : 32'd3, 32'(frame_len));
        if (frame_cmd == cmd)
          hits++;
      end
    end
    found = (hits == 2);
  endtask

  initial begin
    bit found;
    err_cnt     = 0;
    timeout_cnt = 0;
    found       = 1'b1;
    clk         = 1'b1;  // reset from time 0
    btn2        = 1'b0;
    cmd_order   = '{8'h10, 8'h11, 8'h20, 8'h21, 8'h30, 8'h31};
    for (int i = 0; i < MAX_STEPS; i++)
      steps[i] = {8'hff, 32'(i)};  // press count ff marks an unused entry
    $readmemh("sim/spi_golden.txt", steps);

    repeat (2) @(posedge rst);
    clk <= 1'b0;
    @(negedge rst);
    check_value("reset ss_n", 32'd1, 32'(ss_n));
    check_value("reset running", 32'd0, 32'(running));

    for (int i = 0; i < MAX_STEPS && found; i++) begin
      if (steps[i][39:32] != 8'hff) begin
        press_button(int'(steps[i][39:32]));
        wait_for_command(steps[i][31:24], found);
        if (!found) begin
          $display("timeout in step %0d, command %h was not seen twice", i, steps[i][31:24]);
          timeout_cnt++;
        end else begin
          check_value($sformatf("step %0d payload", i), 32'(steps[i][23:0]), 32'(frame_pay));
          check_value($sformatf("step %0d status", i), 32'(frame_status), 32'(status));
          check_value($sformatf("step %0d running", i), 32'd1, 32'(running));
        end
      end
    end

    $display("tb_btntest_spi done: %0d errors, %0d timeouts", err_cnt, timeout_cnt);
    if (err_cnt == 0 && timeout_cnt == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

endmodule

/* sim/spi_golden.txt */
// one step per line, 40 bits packed as pp cc rrggbb
// pp presses before the check, cc command to watch, rrggbb expected payload (motor in bb)
0010000000
0011000000
0020000000
0021000000
0030000000
0031000000
0110000020
0111000020
0120000020
0121002000
0130200000
0131202020
0610000040
0621006000
0620000080
0031808080
0030800000
0631000000
0030000000
06100000c0
00110000c0
0610000000
0011000000
0020000040

/* gopigo_spi.f */
hdl/gopigo_spi_pkg.sv
hdl/spi_byte_master.sv
hdl/spi_frame_sequencer.sv
hdl/top_spi_controller.sv
hdl/btntest_spi_controller.sv
sim/tb_clk_gen.sv
sim/tb_spi_slave_model.sv
sim/tb_btntest_spi.sv

/* Makefile */
SIM        = verilator
SIM_FLAGS  = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only --timing -Wall
TOP        = tb_btntest_spi
FILELIST   = gopigo_spi.f
PASS_MSG   = PASS: all tests

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qxF "$(PASS_MSG)"

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir
